//--- list.f
source/mapper_pkg.sv
source/mapper_cfg_if.sv
source/mapper_regs.sv
source/region_decoder.sv
source/dtack_timer.sv
source/sound_mailbox.sv
source/mapper_top.sv
testbench/mapper_tb.sv

//--- source/dtack_timer.sv
`timescale 1ns/1ps

module dtack_timer (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_as_n,
    input  logic        ext_ack,
    output logic        cpu_dtack_n,
    mapper_cfg_if.timer cfg
);
    import mapper_pkg::*;

    logic [1:0] cnt;     // edges seen with the strobe low
    logic [1:0] target;

    always_comb begin
        case (cfg.sel_wait)
            wait_1:  target = 2'd1;
            wait_2:  target = 2'd2;
            wait_3:  target = 2'd3;
            default: target = 2'd1;  // wait_ext, counting starts at ext_ack
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt         <= '0;
            cpu_dtack_n <= 1'b1;
        end else if (cpu_as_n) begin
            // strobe released, end of bus cycle
            cnt         <= '0;
            cpu_dtack_n <= 1'b1;
        end else if (cpu_dtack_n) begin
            if (cfg.sel_wait == wait_ext) begin
                if (cnt != 2'd0) begin
                    cpu_dtack_n <= 1'b0;
                end else if (ext_ack) begin
                    cnt <= 2'd1;
                end
            end else if (cnt == target) begin
                cpu_dtack_n <= 1'b0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    a_dtack_release: assert property (@(posedge clk) disable iff (rst)
        cpu_as_n |=> cpu_dtack_n);

endmodule

//--- source/mapper_cfg_if.sv
`timescale 1ns/1ps

interface mapper_cfg_if;
    import mapper_pkg::*;

    // region setup, straight out of the register file
    logic [7:0]   region_base [NUM_REGIONS];
    region_size_e region_size [NUM_REGIONS];
    wait_mode_e   region_wait [NUM_REGIONS];

    // decode of the access in progress
    wait_mode_e   sel_wait;
    logic         region_none;

    modport regs (
        output region_base, region_size, region_wait,
        input  region_none
    );

    modport decoder (
        input  region_base, region_size, region_wait,
        output sel_wait, region_none
    );

    modport timer (
        input sel_wait
    );

endinterface

//--- source/mapper_pkg.sv
package mapper_pkg;

    localparam int NUM_REGIONS = 8;

    // field widths
    localparam int REG_AW = 5;   // register address
    localparam int DATA_W = 8;   // register byte
    localparam int BUS_DW = 16;  // system bus data
    localparam int IPL_W  = 3;

    // region size code, sets how many bits of addr[23:16] take part in the compare
    typedef enum logic [1:0] {
        size_64k  = 2'd0,  // 8 bits
        size_128k = 2'd1,  // 7 bits
        size_512k = 2'd2,  // 5 bits
        size_2m   = 2'd3   // 3 bits
    } region_size_e;

    typedef enum logic [1:0] {
        wait_1   = 2'd0,
        wait_2   = 2'd1,
        wait_3   = 2'd2,
        wait_ext = 2'd3    // DTACK follows ext_ack
    } wait_mode_e;

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_write = 2'd1,
        op_read  = 2'd2,
        op_none2 = 2'd3
    } master_op_e;

    typedef enum logic {
        st_idle     = 1'b0,
        st_wait_ack = 1'b1
    } ctrl_state_e;

    // register map
    localparam logic [REG_AW-1:0] REG_DATA_HI = 5'd0;
    localparam logic [REG_AW-1:0] REG_DATA_LO = 5'd1;
    localparam logic [REG_AW-1:0] REG_STATUS  = 5'd2;
    localparam logic [REG_AW-1:0] REG_SND_OUT = 5'd3;
    localparam logic [REG_AW-1:0] REG_IRQ     = 5'd4;
    localparam logic [REG_AW-1:0] REG_CMD     = 5'd5;
    localparam logic [REG_AW-1:0] REG_SND_IN  = 5'd6;
    localparam logic [REG_AW-1:0] REG_RDADDR  = 5'd7;   // 7..9, high byte first
    localparam logic [REG_AW-1:0] REG_WRADDR  = 5'd10;  // 10..12
    localparam logic [REG_AW-1:0] REG_REGION  = 5'd16;  // size/wait at 16+2r, base at 17+2r

endpackage

//--- source/mapper_regs.sv
`timescale 1ns/1ps

module mapper_regs #(
    parameter int BUS_TIMEOUT = 64
) (
    input  logic                           clk,
    input  logic                           rst,
    // microcontroller side
    input  logic                           mcu_wr,
    input  logic                           mcu_rd,
    input  logic [mapper_pkg::REG_AW-1:0]  mcu_addr,
    input  logic [mapper_pkg::DATA_W-1:0]  mcu_wdata,
    output logic [mapper_pkg::DATA_W-1:0]  mcu_rdata,
    // main CPU side
    input  logic                           cpu_reg_wr,
    input  logic [mapper_pkg::REG_AW-1:0]  cpu_reg_addr,
    input  logic [mapper_pkg::DATA_W-1:0]  cpu_reg_wdata,
    input  logic                           cpu_inta,
    output logic [mapper_pkg::IPL_W-1:0]   cpu_ipl_n,
    // bus master
    output logic                           bus_req,
    output logic                           bus_we,
    output logic [23:1]                    bus_addr,
    output logic [mapper_pkg::BUS_DW-1:0]  bus_wdata,
    input  logic                           bus_ack,
    input  logic [mapper_pkg::BUS_DW-1:0]  bus_rdata,
    // sound mailbox
    output logic [mapper_pkg::DATA_W-1:0]  snd_out_byte,
    output logic                           snd_out_wr,
    output logic                           snd_in_rd,
    input  logic [mapper_pkg::DATA_W-1:0]  snd_in_byte,
    input  logic                           snd_full,
    mapper_cfg_if.regs                     cfg
);
    import mapper_pkg::*;

    localparam int TW = $clog2(BUS_TIMEOUT + 1);

    logic [DATA_W-1:0] mmr [32];
    logic              cpu_locked;   // set by the first mcu write, held until reset
    logic              wr_en;
    logic [REG_AW-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    master_op_e        wr_op;
    logic              cmd_start;
    ctrl_state_e       state;
    logic [TW-1:0]     tmo_cnt;
    logic              bus_err;
    logic [DATA_W-1:0] status;

    // mcu wins over a cpu write in the same cycle
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = mcu_addr;
        wr_data = mcu_wdata;
        if (mcu_wr) begin
            wr_en = 1'b1;
        end else if (cpu_reg_wr && !cpu_locked && cfg.region_none) begin
            wr_en   = 1'b1;
            wr_addr = cpu_reg_addr;
            wr_data = cpu_reg_wdata;
        end
    end

    assign wr_op     = master_op_e'(wr_data[1:0]);
    assign cmd_start = wr_en && wr_addr == REG_CMD && state == st_idle &&
                       (wr_op == op_write || wr_op == op_read);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                mmr[i] <= '0;
            end
            mmr[REG_IRQ] <= 8'd7;
            cpu_locked   <= 1'b0;
        end else begin
            if (mcu_wr) cpu_locked <= 1'b1;
            if (wr_en) mmr[wr_addr] <= wr_data;
            // read data from the bus lands in the data pair
            if (state == st_wait_ack && bus_ack && !bus_we) begin
                mmr[REG_DATA_HI] <= bus_rdata[15:8];
                mmr[REG_DATA_LO] <= bus_rdata[7:0];
            end
            if (cpu_inta) mmr[REG_IRQ][2:0] <= 3'd7;  // ack drops the level
        end
    end

    // bus master FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            bus_req <= 1'b0;
            bus_we  <= 1'b0;
            bus_err <= 1'b0;
            tmo_cnt <= '0;
        end else begin
            bus_req <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_start) begin
                        state   <= st_wait_ack;
                        bus_req <= 1'b1;
                        bus_we  <= wr_op == op_write;
                        bus_err <= 1'b0;
                        tmo_cnt <= '0;
                    end
                end
                st_wait_ack: begin
                    if (bus_ack) begin
                        state <= st_idle;
                    end else if (tmo_cnt == TW'(BUS_TIMEOUT - 1)) begin
                        state   <= st_idle;
                        bus_err <= 1'b1;   // nobody answered
                    end else begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign bus_addr  = bus_we ? {mmr[REG_WRADDR][6:0], mmr[REG_WRADDR + 1], mmr[REG_WRADDR + 2]}
                              : {mmr[REG_RDADDR][6:0], mmr[REG_RDADDR + 1], mmr[REG_RDADDR + 2]};
    assign bus_wdata = {mmr[REG_DATA_HI], mmr[REG_DATA_LO]};

    assign status = {5'd0, snd_full, bus_err, state == st_wait_ack};

    always_ff @(posedge clk) begin
        if (mcu_rd) begin
            if (mcu_addr == REG_STATUS) begin
                mcu_rdata <= status;
            end else if (mcu_addr == REG_SND_IN) begin
                mcu_rdata <= snd_in_byte;
            end else begin
                mcu_rdata <= mmr[mcu_addr];
            end
        end
    end

    // the mailbox latches the byte as it is written
    assign snd_out_wr   = wr_en && wr_addr == REG_SND_OUT;
    assign snd_out_byte = wr_data;
    assign snd_in_rd    = mcu_rd && mcu_addr == REG_SND_IN;

    assign cpu_ipl_n = mmr[REG_IRQ][2:0];

    always_comb begin
        for (int r = 0; r < NUM_REGIONS; r++) begin
            cfg.region_base[r] = mmr[REG_REGION + 2 * r + 1];
            cfg.region_size[r] = region_size_e'(mmr[REG_REGION + 2 * r][1:0]);
            cfg.region_wait[r] = wait_mode_e'(mmr[REG_REGION + 2 * r][3:2]);
        end
    end

    a_req_from_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_req) |-> $past(state) == st_idle);

    a_inta_clears_ipl: assert property (@(posedge clk) disable iff (rst)
        cpu_inta |=> cpu_ipl_n == 3'd7);

endmodule

//--- source/mapper_top.sv
`timescale 1ns/1ps

module mapper_top #(
    parameter int BUS_TIMEOUT = 64
) (
    input  logic                               clk,
    input  logic                               rst,
    // microcontroller
    input  logic                               mcu_wr,
    input  logic                               mcu_rd,
    input  logic [mapper_pkg::REG_AW-1:0]      mcu_addr,
    input  logic [mapper_pkg::DATA_W-1:0]      mcu_wdata,
    output logic [mapper_pkg::DATA_W-1:0]      mcu_rdata,
    output logic                               mcu_snd_irq_n,
    // 68000 bus
    input  logic                               cpu_as_n,
    input  logic [23:1]                        cpu_addr,
    input  logic                               cpu_reg_wr,
    input  logic [mapper_pkg::REG_AW-1:0]      cpu_reg_addr,
    input  logic [mapper_pkg::DATA_W-1:0]      cpu_reg_wdata,
    input  logic                               cpu_inta,
    input  logic                               ext_ack,
    output logic                               cpu_dtack_n,
    output logic [mapper_pkg::IPL_W-1:0]       cpu_ipl_n,
    output logic [mapper_pkg::NUM_REGIONS-1:0] region_sel,
    output logic                               region_none,
    // master access
    output logic                               bus_req,
    output logic                               bus_we,
    output logic [23:1]                        bus_addr,
    output logic [mapper_pkg::BUS_DW-1:0]      bus_wdata,
    input  logic                               bus_ack,
    input  logic [mapper_pkg::BUS_DW-1:0]      bus_rdata,
    // sound CPU
    input  logic                               snd_wr,
    input  logic                               snd_rd,
    input  logic [mapper_pkg::DATA_W-1:0]      snd_din,
    output logic [mapper_pkg::DATA_W-1:0]      snd_dout,
    output logic                               snd_full
);
    import mapper_pkg::*;

    logic [DATA_W-1:0] snd_out_byte;
    logic [DATA_W-1:0] snd_in_byte;
    logic              snd_out_wr;
    logic              snd_in_rd;

    mapper_cfg_if cfg_if ();

    mapper_regs #(.BUS_TIMEOUT(BUS_TIMEOUT)) u_regs (
        .clk, .rst,
        .mcu_wr, .mcu_rd, .mcu_addr, .mcu_wdata, .mcu_rdata,
        .cpu_reg_wr, .cpu_reg_addr, .cpu_reg_wdata, .cpu_inta, .cpu_ipl_n,
        .bus_req, .bus_we, .bus_addr, .bus_wdata, .bus_ack, .bus_rdata,
        .snd_out_byte, .snd_out_wr, .snd_in_rd, .snd_in_byte, .snd_full,
        .cfg (cfg_if.regs)
    );

    region_decoder u_decoder (
        .cpu_as_n, .cpu_addr, .region_sel, .region_none,
        .cfg (cfg_if.decoder)
    );

    dtack_timer u_dtack (
        .clk, .rst, .cpu_as_n, .ext_ack, .cpu_dtack_n,
        .cfg (cfg_if.timer)
    );

    sound_mailbox u_mailbox (
        .clk, .rst,
        .snd_wr, .snd_rd, .snd_din, .snd_dout, .snd_full,
        .snd_out_wr, .snd_in_rd, .snd_out_byte, .snd_in_byte,
        .mcu_snd_irq_n
    );

endmodule

//--- source/region_decoder.sv
`timescale 1ns/1ps

module region_decoder (
    input  logic                               cpu_as_n,
    input  logic [23:1]                        cpu_addr,
    output logic [mapper_pkg::NUM_REGIONS-1:0] region_sel,
    output logic                               region_none,
    mapper_cfg_if.decoder                      cfg
);
    import mapper_pkg::*;

    logic [NUM_REGIONS-1:0] hit;
    logic                   found;
    wait_mode_e             sel_wait;

    // base compare over the width set by the size code
    always_comb begin
        hit = '0;
        for (int r = 0; r < NUM_REGIONS; r++) begin
            case (cfg.region_size[r])
                size_64k:  hit[r] = cpu_addr[23:16] == cfg.region_base[r];
                size_128k: hit[r] = cpu_addr[23:17] == cfg.region_base[r][7:1];
                size_512k: hit[r] = cpu_addr[23:19] == cfg.region_base[r][7:3];
                size_2m:   hit[r] = cpu_addr[23:21] == cfg.region_base[r][7:5];
                default:   hit[r] = 1'b0;
            endcase
        end
    end

    // lowest numbered region wins
    always_comb begin
        region_sel = '0;
        found      = 1'b0;
        sel_wait   = wait_1;   // also used when nothing matches
        for (int r = 0; r < NUM_REGIONS; r++) begin
            if (!found && hit[r]) begin
                region_sel[r] = 1'b1;
                found         = 1'b1;
                sel_wait      = cfg.region_wait[r];
            end
        end
        if (cpu_as_n) begin
            region_sel = '0;
            found      = 1'b0;
            sel_wait   = wait_1;
        end
    end

    assign region_none     = !cpu_as_n && !found;
    assign cfg.region_none = region_none;
    assign cfg.sel_wait    = sel_wait;

    always_comb begin
        a_sel_onehot: assert #0 ($onehot0(region_sel))
            else $error("region_sel has more than one bit set: %b", region_sel);
    end

endmodule

//--- source/sound_mailbox.sv
`timescale 1ns/1ps

module sound_mailbox (
    input  logic                          clk,
    input  logic                          rst,
    // sound CPU side
    input  logic                          snd_wr,
    input  logic                          snd_rd,
    input  logic [mapper_pkg::DATA_W-1:0] snd_din,
    output logic [mapper_pkg::DATA_W-1:0] snd_dout,
    output logic                          snd_full,
    // register file side
    input  logic                          snd_out_wr,
    input  logic                          snd_in_rd,
    input  logic [mapper_pkg::DATA_W-1:0] snd_out_byte,
    output logic [mapper_pkg::DATA_W-1:0] snd_in_byte,
    output logic                          mcu_snd_irq_n
);
    import mapper_pkg::*;

    logic [DATA_W-1:0] out_latch;  // towards the sound CPU
    logic [DATA_W-1:0] in_latch;   // from the sound CPU

    always_ff @(posedge clk) begin
        if (snd_out_wr) out_latch <= snd_out_byte;
        if (snd_wr) in_latch <= snd_din;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_full      <= 1'b0;
            mcu_snd_irq_n <= 1'b1;
        end else begin
            if (snd_rd) snd_full <= 1'b0;
            if (snd_out_wr) snd_full <= 1'b1;  // a new byte beats a read in the same cycle
            if (snd_in_rd) mcu_snd_irq_n <= 1'b1;
            if (snd_wr) mcu_snd_irq_n <= 1'b0;
        end
    end

    assign snd_dout    = out_latch;
    assign snd_in_byte = in_latch;

endmodule

//--- testbench/mapper_tb.sv
`timescale 1ns/1ps

module mapper_tb;
    import mapper_pkg::*;

    localparam int BUS_TIMEOUT = 20;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   mcu_wr, mcu_rd, mcu_snd_irq_n;
    logic [REG_AW-1:0]      mcu_addr, cpu_reg_addr;
    logic [DATA_W-1:0]      mcu_wdata, mcu_rdata, cpu_reg_wdata, snd_din, snd_dout;
    logic                   cpu_as_n, cpu_reg_wr, cpu_inta, ext_ack, cpu_dtack_n;
    logic [23:1]            cpu_addr, bus_addr;
    logic [IPL_W-1:0]       cpu_ipl_n;
    logic [NUM_REGIONS-1:0] region_sel;
    logic                   region_none, bus_req, bus_we, bus_ack;
    logic [BUS_DW-1:0]      bus_wdata, bus_rdata;
    logic                   snd_wr, snd_rd, snd_full;

    logic [DATA_W-1:0] mdl [32];   // register file model
    logic [31:0]       rng = 32'h2da6;
    logic              err_mdl = 1'b0;
    logic              full_mdl = 1'b0;
    logic              decode_on = 1'b0;
    int                req_count = 0;

    mapper_top #(.BUS_TIMEOUT(BUS_TIMEOUT)) DUT (
        .clk, .rst, .mcu_wr, .mcu_rd, .mcu_addr, .mcu_wdata, .mcu_rdata, .mcu_snd_irq_n,
        .cpu_as_n, .cpu_addr, .cpu_reg_wr, .cpu_reg_addr, .cpu_reg_wdata, .cpu_inta,
        .ext_ack, .cpu_dtack_n, .cpu_ipl_n, .region_sel, .region_none,
        .bus_req, .bus_we, .bus_addr, .bus_wdata, .bus_ack, .bus_rdata,
        .snd_wr, .snd_rd, .snd_din, .snd_dout, .snd_full
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // lowest region whose compared high bits equal its base
    function automatic logic [NUM_REGIONS-1:0] exp_region(input logic [7:0] hb);
        logic [7:0] mask;
        for (int r = 0; r < NUM_REGIONS; r++) begin
            case (region_size_e'(mdl[REG_REGION + 2 * r][1:0]))
                size_64k:  mask = 8'hff;
                size_128k: mask = 8'hfe;
                size_512k: mask = 8'hf8;
                default:   mask = 8'he0;
            endcase
            if (((hb ^ mdl[REG_REGION + 2 * r + 1]) & mask) == 8'h00) return 8'h01 << r;
        end
        return '0;
    endfunction

    function automatic wait_mode_e exp_wait(input logic [7:0] hb);
        logic [NUM_REGIONS-1:0] sel;
        sel = exp_region(hb);
        for (int r = 0; r < NUM_REGIONS; r++) begin
            if (sel[r]) return wait_mode_e'(mdl[REG_REGION + 2 * r][3:2]);
        end
        return wait_1;   // no region hit
    endfunction

    function automatic logic [DATA_W-1:0] exp_status(input logic busy, err, full);
        return {5'd0, full, err, busy};
    endfunction

    function automatic int exp_dtack_cycles(input wait_mode_e w);
        case (w)
            wait_2:  return 2;
            wait_3:  return 3;
            default: return 1;   // wait_ext counts from ext_ack
        endcase
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [DATA_W-1:0] got, exp);
        if (got !== exp) abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                             $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                             $time, name, got, exp));
    endtask

    task automatic check_sel(input logic [NUM_REGIONS-1:0] sel, exp_sel,
                             input logic none, exp_none);
        if (sel !== exp_sel) abort_run($sformatf("MISMATCH at %0t: region_sel got %b expected %b",
                                                 $time, sel, exp_sel));
        check_flag("region_none", none, exp_none);
    endtask

    task automatic check_dtack_cycles(input wait_mode_e w, input int got, exp);
        if (got != exp) begin
            abort_run($sformatf("MISMATCH at %0t: cpu_dtack_n cycles (%s) got %0d expected %0d",
                                $time, w.name(), got, exp));
        end
    endtask

    task automatic check_bus_op(input logic we, exp_we, input logic [23:1] addr, exp_addr,
                                input logic [BUS_DW-1:0] wdata, exp_wdata);
        check_flag("bus_we", we, exp_we);
        if (addr !== exp_addr) abort_run($sformatf("MISMATCH at %0t: bus_addr got %h expected %h",
                                                   $time, addr, exp_addr));
        if (wdata !== exp_wdata) begin
            abort_run($sformatf("MISMATCH at %0t: bus_wdata got %h expected %h",
                                $time, wdata, exp_wdata));
        end
    endtask

    task automatic mcu_write(input logic [REG_AW-1:0] a, input logic [DATA_W-1:0] d);
        @(negedge clk);
        mcu_wr    = 1'b1;
        mcu_addr  = a;
        mcu_wdata = d;
        @(negedge clk);
        mcu_wr = 1'b0;
        mdl[a] = d;   // model follows after the capturing edge
    endtask

    task automatic mcu_read(input logic [REG_AW-1:0] a, output logic [DATA_W-1:0] d);
        @(negedge clk);
        mcu_rd   = 1'b1;
        mcu_addr = a;
        @(negedge clk);
        mcu_rd = 1'b0;
        d      = mcu_rdata;
    endtask

    task automatic cpu_write(input logic [REG_AW-1:0] a, input logic [DATA_W-1:0] d,
                             input logic accepted);
        @(negedge clk);
        cpu_reg_wr    = 1'b1;
        cpu_reg_addr  = a;
        cpu_reg_wdata = d;
        @(negedge clk);
        cpu_reg_wr = 1'b0;
        if (accepted) mdl[a] = d;
    endtask

    task automatic measure_dtack(input wait_mode_e w);
        logic [7:0] hb;
        int         cycles;
        int         i;
        hb = next_random();
        mcu_write(REG_REGION, {4'd0, w, size_2m});   // region 0 always wins
        mcu_write(REG_REGION + 1, hb);
        @(negedge clk);
        cpu_as_n = 1'b0;
        cpu_addr = {hb, 15'(next_random())};
        if (w == wait_ext) begin
            for (i = 0; i < 3; i++) begin
                @(negedge clk);
                check_flag("cpu_dtack_n", cpu_dtack_n, 1'b1);   // held off until ext_ack
            end
            ext_ack = 1'b1;
        end
        cycles = 0;
        for (i = 0; i < 16; i++) begin
            @(negedge clk);
            ext_ack = 1'b0;
            if (!cpu_dtack_n) break;
            cycles++;
        end
        if (cpu_dtack_n) abort_run("cpu_dtack_n never fell during the bus cycle");
        check_dtack_cycles(w, cycles, exp_dtack_cycles(exp_wait(hb)));
        cpu_as_n = 1'b1;
        @(negedge clk);
        check_flag("cpu_dtack_n", cpu_dtack_n, 1'b1);
    endtask

    task automatic run_master(input master_op_e op, input logic respond);
        logic [23:1]       exp_addr;
        logic [BUS_DW-1:0] exp_wdata;
        logic [BUS_DW-1:0] rdata;
        logic [DATA_W-1:0] st;
        int                reqs;
        int                i;
        exp_addr = (op == op_write) ? {mdl[10][6:0], mdl[11], mdl[12]}
                                    : {mdl[7][6:0], mdl[8], mdl[9]};
        exp_wdata = {mdl[REG_DATA_HI], mdl[REG_DATA_LO]};
        rdata     = next_random();
        reqs      = req_count;
        mcu_write(REG_CMD, {6'd0, op});
        for (i = 0; i < 8 && !bus_req; i++) @(negedge clk);
        if (!bus_req) abort_run("bus_req did not pulse after a command write");
        check_bus_op(bus_we, op == op_write, bus_addr, exp_addr, bus_wdata, exp_wdata);
        mcu_write(REG_CMD, {6'd0, op_write});   // busy, so this one is dropped
        if (respond) begin
            repeat (next_random() % 5) @(negedge clk);
            bus_ack   = 1'b1;
            bus_rdata = rdata;
            @(negedge clk);
            bus_ack = 1'b0;
            if (op == op_read) begin
                mdl[REG_DATA_HI] = rdata[15:8];
                mdl[REG_DATA_LO] = rdata[7:0];
            end
        end
        err_mdl = !respond;
        for (i = 0; i < 4 * BUS_TIMEOUT; i++) begin
            mcu_read(REG_STATUS, st);
            if (!st[0]) break;
        end
        if (st[0]) abort_run("bus master stayed busy");
        check_byte("status", st, exp_status(1'b0, err_mdl, full_mdl));
        if (req_count != reqs + 1) abort_run("wrong number of bus_req pulses for one command");
        mcu_read(REG_DATA_HI, st);
        check_byte("mcu_rdata", st, mdl[REG_DATA_HI]);
        mcu_read(REG_DATA_LO, st);
        check_byte("mcu_rdata", st, mdl[REG_DATA_LO]);
    endtask

    // decode compare, runs on every edge once reset is over
    always @(posedge clk) begin
        if (decode_on) begin
            if (cpu_as_n) check_sel(region_sel, '0, region_none, 1'b0);
            else check_sel(region_sel, exp_region(cpu_addr[23:16]),
                           region_none, exp_region(cpu_addr[23:16]) == '0);
        end
    end

    always @(posedge clk) if (bus_req) req_count++;

    initial begin
        #200000;
        $display("simulation ran far too long, something is stuck");
        $display("=== FAIL ===");
        $fatal(1, "watchdog");
    end

    initial begin
        logic [31:0]       r;
        logic [REG_AW-1:0] a;
        logic [DATA_W-1:0] d;
        logic [DATA_W-1:0] got;
        rst = 1'b1;
        {mcu_wr, mcu_rd, mcu_addr, mcu_wdata} = '0;
        {cpu_reg_wr, cpu_reg_addr, cpu_reg_wdata, cpu_inta, ext_ack} = '0;
        cpu_as_n = 1'b1;
        cpu_addr = '0;
        {bus_ack, bus_rdata, snd_wr, snd_rd, snd_din} = '0;
        for (int k = 0; k < 32; k++) mdl[k] = (k == REG_IRQ) ? 8'd7 : 8'd0;
        repeat (5) @(negedge clk);
        rst       = 1'b0;
        decode_on = 1'b1;

        // reset values
        check_flag("bus_req", bus_req, 1'b0);
        check_flag("cpu_dtack_n", cpu_dtack_n, 1'b1);
        check_flag("mcu_snd_irq_n", mcu_snd_irq_n, 1'b1);
        check_flag("snd_full", snd_full, 1'b0);
        check_byte("cpu_ipl_n", {5'd0, cpu_ipl_n}, 8'd7);
        mcu_read(REG_IRQ, got);
        check_byte("mcu_rdata", got, 8'd7);
        mcu_read(REG_STATUS, got);
        check_byte("status", got, exp_status(1'b0, 1'b0, 1'b0));

        // cpu writes go through until the first mcu write
        @(negedge clk);
        cpu_as_n = 1'b0;
        cpu_addr = {8'h55, 15'd0};   // outside every region at reset
        cpu_write(REG_IRQ, 8'h02, 1'b1);
        check_byte("cpu_ipl_n", {5'd0, cpu_ipl_n}, 8'd2);
        @(negedge clk);
        cpu_inta = 1'b1;
        @(negedge clk);
        cpu_inta     = 1'b0;
        mdl[REG_IRQ] = 8'd7;
        check_byte("cpu_ipl_n", {5'd0, cpu_ipl_n}, 8'd7);
        mcu_write(REG_DATA_HI, next_random());
        cpu_write(REG_IRQ, 8'h03, 1'b0);
        check_byte("cpu_ipl_n", {5'd0, cpu_ipl_n}, 8'd7);
        mcu_read(REG_IRQ, got);
        check_byte("mcu_rdata", got, mdl[REG_IRQ]);
        cpu_as_n = 1'b1;

        // random register read-back, skipping registers with side effects
        for (int i = 0; i < 24; i++) begin
            r = next_random();
            a = r[4:0];
            if (a == REG_STATUS || a == REG_SND_OUT || a == REG_CMD || a == REG_SND_IN) a += 5'd8;
            mcu_write(a, r[15:8]);
            mcu_read(a, got);
            check_byte("mcu_rdata", got, mdl[a]);
            check_byte("cpu_ipl_n", {5'd0, cpu_ipl_n}, {5'd0, mdl[REG_IRQ][2:0]});
        end

        // random regions, then random addresses for the decode process
        for (int i = 0; i < NUM_REGIONS; i++) begin
            mcu_write(REG_REGION + 2 * i, next_random());
            mcu_write(REG_REGION + 2 * i + 1, next_random());
        end
        for (int i = 0; i < 80; i++) begin
            r = next_random();
            d = r[8] ? mdl[REG_REGION + 1 + 2 * r[2:0]] ^ {3'd0, r[20:16]} : r[7:0];
            @(negedge clk);
            cpu_as_n = r[31:28] == 4'd0;
            cpu_addr = {d, r[30:16]};
        end
        @(negedge clk);
        cpu_as_n = 1'b1;

        for (int i = 0; i < 4; i++) measure_dtack(wait_mode_e'(i));

        // bus master
        for (int i = 7; i <= 12; i++) mcu_write(i, next_random());
        mcu_write(REG_DATA_HI, next_random());
        mcu_write(REG_DATA_LO, next_random());
        run_master(op_write, 1'b1);
        run_master(op_read, 1'b1);
        run_master(op_read, 1'b0);   // nobody acks

        // mailbox both ways
        d = next_random();
        mcu_write(REG_SND_OUT, d);
        full_mdl = 1'b1;
        check_flag("snd_full", snd_full, 1'b1);
        check_byte("snd_dout", snd_dout, d);
        mcu_read(REG_STATUS, got);
        check_byte("status", got, exp_status(1'b0, err_mdl, full_mdl));
        @(negedge clk);
        snd_rd = 1'b1;
        @(negedge clk);
        snd_rd   = 1'b0;
        full_mdl = 1'b0;
        check_flag("snd_full", snd_full, 1'b0);
        mcu_read(REG_STATUS, got);
        check_byte("status", got, exp_status(1'b0, err_mdl, full_mdl));
        d = next_random();
        @(negedge clk);
        snd_wr  = 1'b1;
        snd_din = d;
        @(negedge clk);
        snd_wr = 1'b0;
        check_flag("mcu_snd_irq_n", mcu_snd_irq_n, 1'b0);
        mcu_read(REG_SND_IN, got);
        check_byte("mcu_rdata", got, d);
        check_flag("mcu_snd_irq_n", mcu_snd_irq_n, 1'b1);

        $display("=== PASS ===");
        $finish;
    end

endmodule
